/* src.f */
common/motion_pkg.sv
src/request_decoder.sv
motor/rotate_motor_ctl.sv
discharge/discharge_ctl.sv
src/motion_cpu.sv
sim/motor_model.sv
sim/tb_motion_cpu.sv

/* Makefile */
TOP := tb_motion_cpu

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --top-module $(TOP) -f src.f

run: build
	./obj_dir/V$(TOP) | tee /dev/stderr | grep "Finished with no errors" > /dev/null

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f src.f

clean:
	rm -rf obj_dir

/* sim/tb_motion_cpu.sv */
`timescale 1ns/10ps

module tb_motion_cpu;
	import motion_pkg::*;

	localparam int N_TESTS      = 5;
	localparam int MAX_ROWS     = 24;
	localparam int WAIT_LIMIT   = 2000;
	localparam int QUIET_CYCLES = 40;
	localparam bit DIS_DEFAULT  = 1'b1;

	localparam int A_ISSUE = 0; // strobe only
	localparam int A_DONE  = 1; // then wait for req_done
	localparam int A_RUN   = 2; // then wait for the left motor to be busy
	localparam int A_QUIET = 3; // then req_done must stay low for a while

	logic       clk;
	logic       resetn;
	logic       req_en;
	cmd_t       req_cmd;
	req_param_t req_param;
	logic       req_done;
	logic       lr_state, lr_sel, lr_start, lr_stop, lr_abs;
	logic       rr_state, rr_sel, rr_start, rr_stop, rr_abs;
	speed_t     lr_speed, rr_speed, lr_seen_speed, rr_seen_speed;
	step_t      lr_step, rr_step, lr_seen_step, rr_seen_step;
	logic       lr_seen_abs, rr_seen_abs;
	logic       discharge_resetn;
	logic       discharge_drive;

	// stimulus table with one row per request strobe
	int    row_test [MAX_ROWS];
	cmd_t  row_cmd  [MAX_ROWS];
	word_t row_w0   [MAX_ROWS];
	word_t row_w1   [MAX_ROWS];
	word_t row_w2   [MAX_ROWS];
	int    row_act  [MAX_ROWS];
	int    n_rows;

	string t_name       [N_TESTS];
	logic  exp_done     [N_TESTS];
	int    exp_lr_start [N_TESTS];
	int    exp_rr_start [N_TESTS];
	int    exp_lr_stop  [N_TESTS];
	int    exp_drive    [N_TESTS];
	int    exp_rst      [N_TESTS];

	integer seed = 32'hdc616c24;
	int     errors = 0;
	int     wd_cycles = 0;
	int     lr_row, rr_row, lr_exe_row, rr_exe_row;
	int     lr_starts = 0, rr_starts = 0, lr_stops = 0, rr_stops = 0;
	int     drive_cyc = 0, rst_cyc = 0, overlap = 0;

	motion_cpu #(.C_DISCHARGE_DEFAULT(DIS_DEFAULT)) u_motion_cpu (
		.clk(clk), .resetn(resetn), .req_en(req_en), .req_cmd(req_cmd),
		.req_param(req_param), .req_done(req_done),
		.lr_state(lr_state), .lr_sel(lr_sel), .lr_start(lr_start), .lr_stop(lr_stop),
		.lr_speed(lr_speed), .lr_step(lr_step), .lr_abs(lr_abs),
		.rr_state(rr_state), .rr_sel(rr_sel), .rr_start(rr_start), .rr_stop(rr_stop),
		.rr_speed(rr_speed), .rr_step(rr_step), .rr_abs(rr_abs),
		.discharge_resetn(discharge_resetn), .discharge_drive(discharge_drive)
	);

	motor_model u_lr_model (
		.clk(clk), .resetn(resetn), .sel(lr_sel), .start(lr_start), .stop(lr_stop),
		.speed(lr_speed), .step(lr_step), .abs_mode(lr_abs), .state(lr_state),
		.seen_speed(lr_seen_speed), .seen_step(lr_seen_step), .seen_abs(lr_seen_abs)
	);

	motor_model u_rr_model (
		.clk(clk), .resetn(resetn), .sel(rr_sel), .start(rr_start), .stop(rr_stop),
		.speed(rr_speed), .step(rr_step), .abs_mode(rr_abs), .state(rr_state),
		.seen_speed(rr_seen_speed), .seen_step(rr_seen_step), .seen_abs(rr_seen_abs)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// running totals sampled away from the active edge
	always @(negedge clk) begin
		if (lr_start) lr_starts++;
		if (rr_start) rr_starts++;
		if (lr_stop) lr_stops++;
		if (rr_stop) rr_stops++;
		if (discharge_drive != DIS_DEFAULT) drive_cyc++;
		if (discharge_resetn) rst_cyc++;
		if (req_done && (lr_state || rr_state)) overlap++;
	end

	initial begin
		wait (wd_cycles > 0);
		repeat (wd_cycles) @(posedge clk);
		$display("watchdog expired after %0d cycles, the run hung", wd_cycles);
		$display("Finished with errors");
		$finish;
	end

	task automatic report_mismatch(input string name, input word_t got, input word_t exp);
		$display("ERR %s got %h expected %h", name, got, exp);
		errors++;
	endtask

	task automatic add_row(input int test, input int cmd, input word_t w0, input word_t w1,
			input word_t w2, input int act);
		row_test[n_rows] = test;
		row_cmd[n_rows]  = cmd_t'(cmd);
		row_w0[n_rows]   = w0;
		row_w1[n_rows]   = w1;
		row_w2[n_rows]   = w2;
		row_act[n_rows]  = act;
		n_rows++;
	endtask

	task automatic set_expect(input int t, input string name, input logic done, input int lrs,
			input int rrs, input int lrstop, input int drv, input int rst);
		t_name[t]       = name;
		exp_done[t]     = done;
		exp_lr_start[t] = lrs;
		exp_rr_start[t] = rrs;
		exp_lr_stop[t]  = lrstop;
		exp_drive[t]    = drv;
		exp_rst[t]      = rst;
	endtask

	task automatic build_table();
		int den, num0, num1, n0, n1, s, total;
		n_rows = 0;
		total  = 0;
		s = 8 + ($random(seed) & 15);
		add_row(0, DEV_MOTOR_LR, $random(seed), $random(seed), s, A_ISSUE);
		add_row(0, REQ_EXE, 0, 0, 0, A_DONE);
		set_expect(0, "left motor alone", 1'b1, 1, 0, 0, 0, 0);
		total += s;
		s = 8 + ($random(seed) & 15);
		add_row(1, DEV_MOTOR_LR, $random(seed), $random(seed), s, A_ISSUE);
		total += s;
		s = 30 + ($random(seed) & 15);
		add_row(1, DEV_MOTOR_RR, $random(seed), $random(seed), -s, A_ISSUE); // backwards
		add_row(1, REQ_EXE, 0, 0, 0, A_DONE);
		set_expect(1, "both motors", 1'b1, 1, 1, 0, 0, 0);
		total += s;
		den  = 6 + ($random(seed) & 3);
		num0 = 1 + ($random(seed) & 3);
		num1 = den - 1 - ($random(seed) & 1);
		n0   = 3;
		n1   = 2;
		add_row(2, REQ_CFG, 0, 0, den, A_ISSUE);
		add_row(2, DEV_DISCHARGE, (num1 << 16) | num0, n0, n1, A_ISSUE);
		add_row(2, REQ_EXE, 0, 0, 0, A_DONE);
		set_expect(2, "discharge burst", 1'b1, 0, 0, 0,
			n0 * num0 + n1 * num1, den * (n0 + n1));
		total += den * (n0 + n1);
		add_row(3, DEV_MOTOR_LR, $random(seed), $random(seed), 400, A_ISSUE);
		add_row(3, REQ_EXE, 0, 0, 0, A_RUN);
		add_row(3, REQ_STOP, 0, 0, 0, A_QUIET);
		add_row(3, REQ_EXE, 0, 0, 0, A_QUIET); // nothing staged
		set_expect(3, "stop during run", 1'b0, 1, 0, 1, 0, 0);
		total += 400;
		add_row(4, DEV_MOTOR_LR, $random(seed), $random(seed), 12, A_ISSUE);
		add_row(4, 2, 0, 0, 0, A_ISSUE);
		add_row(4, REQ_EXE, 0, 0, 0, A_QUIET);
		s = 8 + ($random(seed) & 15);
		add_row(4, DEV_MOTOR_LR, $random(seed), $random(seed), s, A_ISSUE);
		add_row(4, REQ_EXE, 0, 0, 0, A_DONE);
		add_row(4, DEV_MOTOR_LR, $random(seed), $random(seed), 5, A_ISSUE); // next request
		set_expect(4, "unknown command", 1'b0, 1, 0, 0, 0, 0);
		total += s;
		wd_cycles = total + n_rows * (QUIET_CYCLES + 50) + 200;
	endtask

	task automatic send_request(input cmd_t cmd, input word_t w0, input word_t w1,
			input word_t w2);
		@(posedge clk);
		#1;
		req_en    = 1'b1;
		req_cmd   = cmd;
		req_param = {64'h0, w2, w1, w0};
		@(posedge clk);
		#1;
		req_en = 1'b0;
		@(negedge clk);
		if (req_done !== 1'b0)
			report_mismatch("req_done", 32'(req_done), 32'h0);
	endtask

	task automatic apply_row(input int r);
		int n;
		int bad;
		n   = 0;
		bad = 0;
		if (row_cmd[r] == DEV_MOTOR_LR) lr_row = r;
		if (row_cmd[r] == DEV_MOTOR_RR) rr_row = r;
		if (row_cmd[r] == REQ_EXE) begin
			lr_exe_row = lr_row;
			rr_exe_row = rr_row;
		end
		send_request(row_cmd[r], row_w0[r], row_w1[r], row_w2[r]);
		if (row_act[r] == A_DONE) begin
			while (req_done !== 1'b1 && n < WAIT_LIMIT) begin
				@(negedge clk);
				n++;
			end
			if (req_done !== 1'b1) begin
				$display("req_done did not rise within %0d cycles of row %0d", WAIT_LIMIT, r);
				errors++;
			end
		end else if (row_act[r] == A_RUN) begin
			while (lr_state !== 1'b1 && n < WAIT_LIMIT) begin
				@(negedge clk);
				n++;
			end
			if (lr_state !== 1'b1) begin
				$display("left motor never became busy after row %0d", r);
				errors++;
			end
		end else if (row_act[r] == A_QUIET) begin
			repeat (QUIET_CYCLES) begin
				@(negedge clk);
				if (req_done !== 1'b0) bad++;
			end
			if (bad != 0) begin
				$display("req_done rose after row %0d where no device should finish", r);
				errors++;
			end
		end
	endtask

	initial begin
		int t, r, err0, failed;
		int lr_s0, rr_s0, stop0, rr_stop0, drv0, rst0, ov0;
		failed    = 0;
		resetn    = 1'b0;
		req_en    = 1'b0;
		req_cmd   = '0;
		req_param = '0;
		build_table();
		repeat (3) @(posedge clk);
		#1 resetn = 1'b1;
		@(negedge clk);
		if (discharge_drive !== DIS_DEFAULT)
			report_mismatch("discharge_drive", 32'(discharge_drive), 32'(DIS_DEFAULT));
		if (discharge_resetn !== 1'b0)
			report_mismatch("discharge_resetn", 32'(discharge_resetn), 32'h0);
		for (t = 0; t < N_TESTS; t++) begin
			err0     = errors;
			lr_s0    = lr_starts;
			rr_s0    = rr_starts;
			stop0    = lr_stops;
			rr_stop0 = rr_stops;
			drv0     = drive_cyc;
			rst0     = rst_cyc;
			ov0      = overlap;
			for (r = 0; r < n_rows; r++)
				if (row_test[r] == t)
					apply_row(r);
			repeat (2) @(negedge clk);
			if (lr_starts - lr_s0 != exp_lr_start[t])
				report_mismatch("lr_start", lr_starts - lr_s0, exp_lr_start[t]);
			if (rr_starts - rr_s0 != exp_rr_start[t])
				report_mismatch("rr_start", rr_starts - rr_s0, exp_rr_start[t]);
			if (lr_stops - stop0 != exp_lr_stop[t])
				report_mismatch("lr_stop", lr_stops - stop0, exp_lr_stop[t]);
			if (rr_stops != rr_stop0) // right motor is never aborted
				report_mismatch("rr_stop", rr_stops - rr_stop0, 32'h0);
			if (drive_cyc - drv0 != exp_drive[t])
				report_mismatch("discharge_drive", drive_cyc - drv0, exp_drive[t]);
			if (rst_cyc - rst0 != exp_rst[t])
				report_mismatch("discharge_resetn", rst_cyc - rst0, exp_rst[t]);
			if (overlap != ov0) begin
				$display("req_done was high while a motor was still busy");
				errors++;
			end
			if (req_done !== exp_done[t])
				report_mismatch("req_done", 32'(req_done), 32'(exp_done[t]));
			if (exp_lr_start[t] > 0) begin
				if (lr_seen_speed !== row_w1[lr_exe_row])
					report_mismatch("lr_speed", lr_seen_speed, row_w1[lr_exe_row]);
				if (lr_seen_step !== row_w2[lr_exe_row])
					report_mismatch("lr_step", lr_seen_step, row_w2[lr_exe_row]);
				if (lr_seen_abs !== row_w0[lr_exe_row][1])
					report_mismatch("lr_abs", 32'(lr_seen_abs), 32'(row_w0[lr_exe_row][1]));
			end
			if (exp_rr_start[t] > 0) begin
				if (rr_seen_speed !== row_w1[rr_exe_row])
					report_mismatch("rr_speed", rr_seen_speed, row_w1[rr_exe_row]);
				if (rr_seen_step !== row_w2[rr_exe_row])
					report_mismatch("rr_step", rr_seen_step, row_w2[rr_exe_row]);
				if (rr_seen_abs !== row_w0[rr_exe_row][1])
					report_mismatch("rr_abs", 32'(rr_seen_abs), 32'(row_w0[rr_exe_row][1]));
			end
			if (errors == err0)
				$display("test %0d %s: ok", t + 1, t_name[t]);
			else begin
				$display("test %0d %s: failed", t + 1, t_name[t]);
				failed++;
			end
		end
		$display("tests %0d, failed %0d, errors %0d", N_TESTS, failed, errors);
		if (errors == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

/* sim/motor_model.sv */
`timescale 1ns/10ps

module motor_model (
	input  logic               clk,
	input  logic               resetn,
	input  logic               sel,
	input  logic               start,
	input  logic               stop,
	input  motion_pkg::speed_t speed,
	input  motion_pkg::step_t  step,
	input  logic               abs_mode,
	output logic               state,
	output motion_pkg::speed_t seen_speed,
	output motion_pkg::step_t  seen_step,
	output logic               seen_abs
);
	import motion_pkg::*;

	word_t remain;
	word_t run_len;

	// |step| busy cycles, a zero step still gives one
	always_comb begin
		if (step == '0)
			run_len = 1;
		else if (step[WORD_W-1])
			run_len = -step;
		else
			run_len = step;
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			state      <= 1'b0;
			remain     <= '0;
			seen_speed <= '0;
			seen_step  <= '0;
			seen_abs   <= 1'b0;
		end else if (sel && start) begin
			state      <= 1'b1;
			remain     <= run_len - 1;
			seen_speed <= speed;
			seen_step  <= step;
			seen_abs   <= abs_mode;
		end else if (stop) begin
			state  <= 1'b0; // run aborted
			remain <= '0;
		end else if (state) begin
			if (remain == '0)
				state <= 1'b0;
			else
				remain <= remain - 1;
		end
	end

endmodule

/* src/motion_cpu.sv */
`timescale 1ns/10ps

module motion_cpu #(
	parameter bit C_DISCHARGE_DEFAULT = 1'b0
) (
	input  logic                   clk,
	input  logic                   resetn,

	input  logic                   req_en,
	input  motion_pkg::cmd_t       req_cmd,
	input  motion_pkg::req_param_t req_param,
	output logic                   req_done,

	// left rotate motor driver
	input  logic                   lr_state,
	output logic                   lr_sel,
	output logic                   lr_start,
	output logic                   lr_stop,
	output motion_pkg::speed_t     lr_speed,
	output motion_pkg::step_t      lr_step,
	output logic                   lr_abs,

	// right rotate motor driver
	input  logic                   rr_state,
	output logic                   rr_sel,
	output logic                   rr_start,
	output logic                   rr_stop,
	output motion_pkg::speed_t     rr_speed,
	output motion_pkg::step_t      rr_step,
	output logic                   rr_abs,

	output logic                   discharge_resetn,
	output logic                   discharge_drive
);
	import motion_pkg::*;

	logic     lr_enable;
	logic     rr_enable;
	logic     dis_enable;
	logic     lr_done;
	logic     rr_done;
	logic     dis_done;

	logic     lr_req_abs;
	speed_t   lr_req_speed;
	step_t    lr_req_step;
	logic     rr_req_abs;
	speed_t   rr_req_speed;
	step_t    rr_req_step;

	pwm_cnt_t dis_denominator;
	pwm_cnt_t dis_numerator0;
	pwm_cnt_t dis_numerator1;
	pwm_num_t dis_number0;
	pwm_num_t dis_number1;

	request_decoder u_request_decoder (
		.clk             (clk),
		.resetn          (resetn),
		.req_en          (req_en),
		.req_cmd         (req_cmd),
		.req_param       (req_param),
		.req_done        (req_done),
		.lr_done         (lr_done),
		.rr_done         (rr_done),
		.dis_done        (dis_done),
		.lr_enable       (lr_enable),
		.rr_enable       (rr_enable),
		.dis_enable      (dis_enable),
		.lr_abs          (lr_req_abs),
		.lr_speed        (lr_req_speed),
		.lr_step         (lr_req_step),
		.rr_abs          (rr_req_abs),
		.rr_speed        (rr_req_speed),
		.rr_step         (rr_req_step),
		.dis_denominator (dis_denominator),
		.dis_numerator0  (dis_numerator0),
		.dis_numerator1  (dis_numerator1),
		.dis_number0     (dis_number0),
		.dis_number1     (dis_number1)
	);

	rotate_motor_ctl u_lr_motor_ctl (
		.clk       (clk),
		.resetn    (resetn),
		.enable    (lr_enable),
		.exe_done  (lr_done),
		.req_abs   (lr_req_abs),
		.req_speed (lr_req_speed),
		.req_step  (lr_req_step),
		.m_state   (lr_state),
		.m_sel     (lr_sel),
		.m_start   (lr_start),
		.m_stop    (lr_stop),
		.m_speed   (lr_speed),
		.m_step    (lr_step),
		.m_abs     (lr_abs)
	);

	rotate_motor_ctl u_rr_motor_ctl (
		.clk       (clk),
		.resetn    (resetn),
		.enable    (rr_enable),
		.exe_done  (rr_done),
		.req_abs   (rr_req_abs),
		.req_speed (rr_req_speed),
		.req_step  (rr_req_step),
		.m_state   (rr_state),
		.m_sel     (rr_sel),
		.m_start   (rr_start),
		.m_stop    (rr_stop),
		.m_speed   (rr_speed),
		.m_step    (rr_step),
		.m_abs     (rr_abs)
	);

	discharge_ctl #(
		.C_DEFAULT_VALUE (C_DISCHARGE_DEFAULT)
	) u_discharge_ctl (
		.clk         (clk),
		.resetn      (resetn),
		.enable      (dis_enable),
		.exe_done    (dis_done),
		.denominator (dis_denominator),
		.numerator0  (dis_numerator0),
		.numerator1  (dis_numerator1),
		.number0     (dis_number0),
		.number1     (dis_number1),
		.o_resetn    (discharge_resetn),
		.drive       (discharge_drive)
	);

endmodule

/* discharge/discharge_ctl.sv */
`timescale 1ns/10ps

module discharge_ctl #(
	parameter bit C_DEFAULT_VALUE = 1'b0
) (
	input  logic                 clk,
	input  logic                 resetn,
	input  logic                 enable,
	output logic                 exe_done,

	input  motion_pkg::pwm_cnt_t denominator,
	input  motion_pkg::pwm_cnt_t numerator0,
	input  motion_pkg::pwm_cnt_t numerator1,
	input  motion_pkg::pwm_num_t number0,
	input  motion_pkg::pwm_num_t number1,

	output logic                 o_resetn,
	output logic                 drive
);
	import motion_pkg::*;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_PHASE0,
		ST_PHASE1,
		ST_DONE
	} state_t;

	state_t   st;
	pwm_cnt_t pwm_cnt; // position inside the period
	pwm_num_t num_cnt; // periods done in this phase
	pwm_cnt_t cur_numerator;
	pwm_num_t cur_number;
	logic     in_phase;
	logic     period_end;
	logic     phase_end;

	assign in_phase      = (st == ST_PHASE0) || (st == ST_PHASE1);
	assign cur_numerator = (st == ST_PHASE1) ? numerator1 : numerator0;
	assign cur_number    = (st == ST_PHASE1) ? number1 : number0;
	assign period_end    = (pwm_cnt == denominator - 1'b1);
	assign phase_end     = period_end && (num_cnt == cur_number - 1'b1);

	always_ff @(posedge clk) begin
		if (!resetn) begin
			st      <= ST_IDLE;
			pwm_cnt <= '0;
			num_cnt <= '0;
		end else if (!enable) begin
			st      <= ST_IDLE;
			pwm_cnt <= '0;
			num_cnt <= '0;
		end else begin
			case (st)
			ST_IDLE: begin
				// empty phases are skipped
				if (number0 != '0)
					st <= ST_PHASE0;
				else if (number1 != '0)
					st <= ST_PHASE1;
				else
					st <= ST_DONE;
			end
			ST_PHASE0, ST_PHASE1: begin
				if (period_end) begin
					pwm_cnt <= '0;
					if (phase_end) begin
						num_cnt <= '0;
						if (st == ST_PHASE0 && number1 != '0)
							st <= ST_PHASE1;
						else
							st <= ST_DONE;
					end else
						num_cnt <= num_cnt + 1'b1;
				end else
					pwm_cnt <= pwm_cnt + 1'b1;
			end
			default: st <= ST_DONE;
			endcase
		end
	end

	assign o_resetn = in_phase;
	// active level is the opposite of idle
	assign drive    = (in_phase && (pwm_cnt < cur_numerator)) ^ C_DEFAULT_VALUE;
	assign exe_done = enable && (st == ST_DONE);

endmodule

/* motor/rotate_motor_ctl.sv */
`timescale 1ns/10ps

module rotate_motor_ctl (
	input  logic               clk,
	input  logic               resetn,
	input  logic               enable,
	output logic               exe_done,

	input  logic               req_abs,
	input  motion_pkg::speed_t req_speed,
	input  motion_pkg::step_t  req_step,

	// stepper driver side
	input  logic               m_state,
	output logic               m_sel,
	output logic               m_start,
	output logic               m_stop,
	output motion_pkg::speed_t m_speed,
	output motion_pkg::step_t  m_step,
	output logic               m_abs
);
	import motion_pkg::*;

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_LAUNCH,
		ST_WAIT_BUSY,
		ST_WAIT_IDLE,
		ST_DONE
	} state_t;

	state_t st;

	always_ff @(posedge clk) begin
		if (!resetn) begin
			st      <= ST_IDLE;
			m_sel   <= 1'b0;
			m_start <= 1'b0;
			m_stop  <= 1'b0;
		end else begin
			m_start <= 1'b0;
			m_stop  <= 1'b0;
			if (!enable) begin
				st <= ST_IDLE;
				// abort a run that is still going, sel held for the stop cycle
				m_stop <= (st != ST_IDLE) && m_state;
				if (st == ST_IDLE)
					m_sel <= 1'b0;
			end else begin
				case (st)
				ST_IDLE: begin
					st    <= ST_LAUNCH;
					m_sel <= 1'b0;
				end
				ST_LAUNCH: begin
					st      <= ST_WAIT_BUSY;
					m_sel   <= 1'b1;
					m_start <= 1'b1;
				end
				ST_WAIT_BUSY: if (m_state) st <= ST_WAIT_IDLE;
				ST_WAIT_IDLE: if (!m_state) st <= ST_DONE;
				default: st <= ST_DONE; // hold until disabled
				endcase
			end
		end
	end

	// request values frozen for the whole run
	always_ff @(posedge clk) begin
		if (enable && st == ST_IDLE) begin
			m_speed <= req_speed;
			m_step  <= req_step;
			m_abs   <= req_abs;
		end
	end

	assign exe_done = enable && (st == ST_DONE);

endmodule

/* src/request_decoder.sv */
`timescale 1ns/10ps

module request_decoder (
	input  logic                  clk,
	input  logic                  resetn,

	input  logic                  req_en,
	input  motion_pkg::cmd_t      req_cmd,
	input  motion_pkg::req_param_t req_param,
	output logic                  req_done,

	input  logic                  lr_done,
	input  logic                  rr_done,
	input  logic                  dis_done,
	output logic                  lr_enable,
	output logic                  rr_enable,
	output logic                  dis_enable,

	output logic                  lr_abs,
	output motion_pkg::speed_t    lr_speed,
	output motion_pkg::step_t     lr_step,
	output logic                  rr_abs,
	output motion_pkg::speed_t    rr_speed,
	output motion_pkg::step_t     rr_step,

	output motion_pkg::pwm_cnt_t  dis_denominator,
	output motion_pkg::pwm_cnt_t  dis_numerator0,
	output motion_pkg::pwm_cnt_t  dis_numerator1,
	output motion_pkg::pwm_num_t  dis_number0,
	output motion_pkg::pwm_num_t  dis_number1
);
	import motion_pkg::*;

	word_t par0;
	word_t par1;
	word_t par2;

	dev_bmp_t stage_bmp; // marked by device commands
	dev_bmp_t oper_bmp;  // devices currently enabled
	dev_bmp_t done_bmp;
	logic     all_done;

	assign par0 = req_param[0*WORD_W +: WORD_W];
	assign par1 = req_param[1*WORD_W +: WORD_W];
	assign par2 = req_param[2*WORD_W +: WORD_W];

	always_comb begin
		done_bmp = '0;
		done_bmp[DEV_MOTOR_LR]  = lr_done;
		done_bmp[DEV_MOTOR_RR]  = rr_done;
		done_bmp[DEV_DISCHARGE] = dis_done;
	end

	// an empty operating set never completes
	assign all_done = (oper_bmp != '0) && ((done_bmp & oper_bmp) == oper_bmp);

	always_ff @(posedge clk) begin
		if (!resetn)
			stage_bmp <= '0;
		else if (req_en) begin
			case (req_cmd)
			DEV_MOTOR_LR:  stage_bmp[DEV_MOTOR_LR]  <= 1'b1;
			DEV_MOTOR_RR:  stage_bmp[DEV_MOTOR_RR]  <= 1'b1;
			DEV_DISCHARGE: stage_bmp[DEV_DISCHARGE] <= 1'b1;
			default:       stage_bmp <= '0;
			endcase
		end else if (all_done)
			stage_bmp <= '0;
	end

	always_ff @(posedge clk) begin
		if (!resetn)
			oper_bmp <= '0;
		else if (req_en) begin
			if (req_cmd == REQ_EXE)
				oper_bmp <= stage_bmp;
			else if (req_cmd == REQ_STOP)
				oper_bmp <= '0;
		end else if (all_done)
			oper_bmp <= '0; // devices drop out for at least one cycle
	end

	always_ff @(posedge clk) begin
		if (!resetn)
			req_done <= 1'b0;
		else if (req_en)
			req_done <= 1'b0;
		else if (all_done)
			req_done <= 1'b1;
	end

	assign lr_enable  = oper_bmp[DEV_MOTOR_LR];
	assign rr_enable  = oper_bmp[DEV_MOTOR_RR];
	assign dis_enable = oper_bmp[DEV_DISCHARGE];

	// motor parameters, word0 bit1 is abs
	always_ff @(posedge clk) begin
		if (req_en && req_cmd == DEV_MOTOR_LR) begin
			lr_abs   <= par0[1];
			lr_speed <= par1;
			lr_step  <= par2;
		end
		if (req_en && req_cmd == DEV_MOTOR_RR) begin
			rr_abs   <= par0[1];
			rr_speed <= par1;
			rr_step  <= par2;
		end
	end

	always_ff @(posedge clk) begin
		if (req_en && req_cmd == DEV_DISCHARGE) begin
			dis_numerator0 <= par0[PWM_CNT_W-1:0];
			dis_numerator1 <= par0[PWM_CNT_W+15:16];
			dis_number0    <= par1;
			dis_number1    <= par2;
		end
	end

	// only the pwm period is left of the config command
	always_ff @(posedge clk) begin
		if (!resetn)
			dis_denominator <= '0;
		else if (req_en && req_cmd == REQ_CFG)
			dis_denominator <= par2[PWM_CNT_W-1:0];
	end

endmodule

/* common/motion_pkg.sv */
package motion_pkg;

	localparam int WORD_W      = 32;
	localparam int PARAM_WORDS = 5;
	localparam int PWM_CNT_W   = 16;

	// host request
	typedef logic [WORD_W-1:0]             word_t;
	typedef logic [WORD_W-1:0]             cmd_t;
	typedef logic [PARAM_WORDS*WORD_W-1:0] req_param_t;

	// rotate motor driver
	typedef logic [WORD_W-1:0]        speed_t;
	typedef logic signed [WORD_W-1:0] step_t;

	// discharge pwm
	typedef logic [PWM_CNT_W-1:0] pwm_cnt_t;
	typedef logic [WORD_W-1:0]    pwm_num_t;

	typedef logic [WORD_W-1:0] dev_bmp_t; // one bit per device index

	// device indices, also their command codes
	localparam int DEV_MOTOR_LR  = 4;
	localparam int DEV_MOTOR_RR  = 5;
	localparam int DEV_DISCHARGE = 8;

	// control commands
	localparam int REQ_CFG  = 29;
	localparam int REQ_EXE  = 30;
	localparam int REQ_STOP = 31;

endpackage
